/* build.f */
src/aud_pkg.sv
src/aud_recorder.sv
src/aud_sample_mem.sv
src/aud_player.sv
src/aud_ctrl.sv
src/aud_top.sv
dv/aud_tb.sv

/* dv/aud_tb.sv */
`timescale 1ns/1ps

module aud_tb;
	import aud_pkg::*;

	localparam int DEPTH = 8;
	// bit clock half period in system cycles
	localparam int HALF_BCLK = 4;
	// lrck low for the left word, then high for the right half
	localparam int LEFT_BCLKS = 18;
	localparam int FRAME_BCLKS = 24;
	localparam int FRAME_CYCLES = FRAME_BCLKS * HALF_BCLK * 2;
	// key vector order is rec, play, stop
	localparam logic [2:0] KEY_STOP = 3'b001;
	localparam logic [2:0] KEY_PLAY = 3'b010;
	localparam logic [2:0] KEY_REC = 3'b100;

	logic        clk_100k;
	logic        rst_n;
	logic        key_stop;
	logic        key_play;
	logic        key_rec;
	logic        bclk;
	logic        adclrck;
	logic        adcdat;
	logic        daclrck;
	vol_t        volume;
	logic        dacdat;
	addr_t       rec_count;
	ctrl_state_t state;

	integer  seed;
	sample_t rec_smp [DEPTH];
	int      n_rec;
	string   test_name;
	int      n_tests;
	int      n_failed_tests;
	int      n_checks;
	int      n_errors;
	int      test_err_start;

	aud_top #(.MEM_DEPTH(DEPTH)) UUT (
		.i_clk_100k  (clk_100k),
		.i_rst_n     (rst_n),
		.i_key_stop  (key_stop),
		.i_key_play  (key_play),
		.i_key_rec   (key_rec),
		.i_bclk      (bclk),
		.i_adclrck   (adclrck),
		.i_adcdat    (adcdat),
		.i_daclrck   (daclrck),
		.i_volume    (volume),
		.o_dacdat    (dacdat),
		.o_rec_count (rec_count),
		.o_state     (state)
	);

	initial begin
		clk_100k = 1'b0;
		forever #20 clk_100k = ~clk_100k;
	end

	task automatic check_sample(input string what, input sample_t exp, input sample_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %h, got %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input addr_t exp, input addr_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %0d, got %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_state(input string what, input ctrl_state_t exp,
			input ctrl_state_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %s, got %s", test_name, what, exp.name(),
				act.name());
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s %s: expected %b, got %b", test_name, what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_start = n_errors;
		n_tests++;
	endtask

	task automatic end_test();
		if (n_errors == test_err_start) begin
			$display("[TEST] %s: passed", test_name);
		end else begin
			n_failed_tests++;
			$display("[TEST] %s: failed with %0d errors", test_name, n_errors - test_err_start);
		end
	endtask

	// one-cycle key pulse that returns once the state has settled
	task automatic pulse_key(input logic [2:0] keys);
		{key_rec, key_play, key_stop} = keys;
		@(negedge clk_100k);
		{key_rec, key_play, key_stop} = 3'b000;
	endtask

	task automatic wait_state(input ctrl_state_t exp, input int max_cycles);
		int n;
		n = 0;
		while (state !== exp && n < max_cycles) begin
			@(negedge clk_100k);
			n++;
		end
		if (state !== exp) begin
			n_errors++;
			$display("%s: state never reached %s within %0d cycles", test_name, exp.name(),
				max_cycles);
		end
	endtask

	// one I2S frame on both codec sides
	// adc bits go out msb first on the falling bclk, ahead of each rise
	task automatic run_frame(input sample_t tx, output sample_t rx, output logic seen_high);
		int p;
		int c;
		rx = '0;
		seen_high = 1'b0;
		for (p = 0; p < FRAME_BCLKS; p++) begin
			bclk = 1'b0;
			if (p == 0) begin
				adclrck = 1'b0;
				daclrck = 1'b0;
			end else if (p == LEFT_BCLKS) begin
				adclrck = 1'b1;
				daclrck = 1'b1;
			end
			adcdat = (p < SAMPLE_W) ? tx[SAMPLE_W-1-p] : 1'b0;
			for (c = 0; c < HALF_BCLK; c++) begin
				@(negedge clk_100k);
				seen_high = seen_high | dacdat;
			end
			// dac word lags lrck by one bit clock
			if (p >= 1 && p <= SAMPLE_W) begin
				rx[SAMPLE_W-p] = dacdat;
			end
			bclk = 1'b1;
			for (c = 0; c < HALF_BCLK; c++) begin
				@(negedge clk_100k);
				seen_high = seen_high | dacdat;
			end
		end
	endtask

	// sends random adc words and can note them as expected memory contents
	task automatic record_frames(input int n, input logic keep);
		sample_t smp;
		sample_t rx;
		logic    hi;
		int      i;
		for (i = 0; i < n; i++) begin
			smp = sample_t'($random(seed));
			run_frame(smp, rx, hi);
			if (keep && n_rec < DEPTH) begin
				rec_smp[n_rec] = smp;
				n_rec++;
			end
		end
	endtask

	// each volume step below 7 halves the word once more
	task automatic play_frames(input int first, input int n, input vol_t vol);
		sample_t rx;
		sample_t exp;
		logic    hi;
		int      i;
		int      k;
		for (i = 0; i < n; i++) begin
			run_frame('0, rx, hi);
			exp = rec_smp[first+i];
			for (k = vol; k < 7; k++) begin
				// halving rounds toward minus infinity
				exp = exp >>> 1;
			end
			check_sample($sformatf("word %0d", first + i), exp, rx);
		end
	endtask

	task automatic idle_after_reset();
		begin_test("reset_idle");
		check_state("state", ST_IDLE, state);
		check_count("rec_count", '0, rec_count);
		check_level("dacdat", 1'b0, dacdat);
		// nothing recorded yet
		pulse_key(KEY_PLAY);
		check_state("state after play", ST_IDLE, state);
		end_test();
	endtask

	task automatic record_five_words();
		begin_test("record_five");
		n_rec = 0;
		pulse_key(KEY_REC);
		check_state("state after rec", ST_REC, state);
		record_frames(5, 1'b1);
		pulse_key(KEY_STOP);
		check_count("rec_count", addr_t'(5), rec_count);
		check_state("state after stop", ST_IDLE, state);
		end_test();
	endtask

	task automatic play_recording(input string name, input vol_t vol);
		begin_test(name);
		volume = vol;
		pulse_key(KEY_PLAY);
		check_state("state after play", ST_PLAY, state);
		play_frames(0, n_rec, vol);
		wait_state(ST_IDLE, FRAME_CYCLES);
		check_state("state at end", ST_IDLE, state);
		end_test();
	endtask

	task automatic pause_record_and_play();
		sample_t rx;
		logic    hi;
		int      i;
		begin_test("pause");
		volume = 3'd7;
		n_rec = 0;
		pulse_key(KEY_REC);
		record_frames(2, 1'b1);
		check_count("rec_count before pause", addr_t'(2), rec_count);
		pulse_key(KEY_REC);
		check_state("state in rec pause", ST_REC_PAUSE, state);
		record_frames(2, 1'b0);
		check_count("rec_count in pause", addr_t'(2), rec_count);
		pulse_key(KEY_REC);
		check_state("state after resume", ST_REC, state);
		record_frames(2, 1'b1);
		pulse_key(KEY_STOP);
		check_count("rec_count after stop", addr_t'(4), rec_count);
		pulse_key(KEY_PLAY);
		play_frames(0, 1, 3'd7);
		pulse_key(KEY_PLAY);
		check_state("state in play pause", ST_PLAY_PAUSE, state);
		for (i = 0; i < 2; i++) begin
			run_frame('0, rx, hi);
			check_sample("word in pause", '0, rx);
			check_level("dacdat seen high in pause", 1'b0, hi);
		end
		pulse_key(KEY_PLAY);
		check_state("state after play resume", ST_PLAY, state);
		play_frames(1, 3, 3'd7);
		wait_state(ST_IDLE, FRAME_CYCLES);
		end_test();
	endtask

	task automatic fill_memory();
		begin_test("memory_full");
		n_rec = 0;
		pulse_key(KEY_REC);
		record_frames(DEPTH + 2, 1'b1);
		wait_state(ST_IDLE, FRAME_CYCLES);
		check_count("rec_count", addr_t'(DEPTH), rec_count);
		// read the whole memory back
		volume = 3'd7;
		pulse_key(KEY_PLAY);
		play_frames(0, DEPTH, 3'd7);
		wait_state(ST_IDLE, FRAME_CYCLES);
		end_test();
	endtask

	initial begin
		seed = 73469;
		n_rec = 0;
		n_tests = 0;
		n_failed_tests = 0;
		n_checks = 0;
		n_errors = 0;
		test_err_start = 0;
		rst_n = 1'b0;
		key_stop = 1'b0;
		key_play = 1'b0;
		key_rec = 1'b0;
		bclk = 1'b0;
		adclrck = 1'b1;
		daclrck = 1'b1;
		adcdat = 1'b0;
		volume = 3'd7;
		repeat (4) @(negedge clk_100k);
		rst_n = 1'b1;
		@(negedge clk_100k);

		idle_after_reset();
		record_five_words();
		play_recording("play_volume_7", 3'd7);
		play_recording("play_volume_5", 3'd5);
		pause_record_and_play();
		fill_memory();

		$display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed_tests,
			n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* src/aud_top.sv */
`timescale 1ns/1ps

module aud_top #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                 i_clk_100k,
	input  logic                 i_rst_n,
	input  logic                 i_key_stop,
	input  logic                 i_key_play,
	input  logic                 i_key_rec,
	input  logic                 i_bclk,
	input  logic                 i_adclrck,
	input  logic                 i_adcdat,
	input  logic                 i_daclrck,
	input  aud_pkg::vol_t        i_volume,
	output logic                 o_dacdat,
	output aud_pkg::addr_t       o_rec_count,
	output aud_pkg::ctrl_state_t o_state
);
	import aud_pkg::*;

	sample_t rec_sample;
	logic    rec_stb;
	mem_wr_t mem_wr;
	addr_t   rd_addr;
	sample_t rd_data;
	logic    play_en;
	logic    fetch;

	aud_ctrl #(.MEM_DEPTH(MEM_DEPTH)) u_ctrl (
		.i_clk_100k   (i_clk_100k),
		.i_rst_n      (i_rst_n),
		.i_key_stop   (i_key_stop),
		.i_key_play   (i_key_play),
		.i_key_rec    (i_key_rec),
		.i_sample     (rec_sample),
		.i_sample_stb (rec_stb),
		.i_fetch      (fetch),
		.o_wr         (mem_wr),
		.o_rd_addr    (rd_addr),
		.o_play_en    (play_en),
		.o_rec_count  (o_rec_count),
		.o_state      (o_state)
	);

	aud_recorder u_recorder (
		.i_clk_100k   (i_clk_100k),
		.i_rst_n      (i_rst_n),
		.i_bclk       (i_bclk),
		.i_adclrck    (i_adclrck),
		.i_adcdat     (i_adcdat),
		.o_sample     (rec_sample),
		.o_sample_stb (rec_stb)
	);

	aud_sample_mem #(.MEM_DEPTH(MEM_DEPTH)) u_mem (
		.i_clk_100k (i_clk_100k),
		.i_wr       (mem_wr),
		.i_rd_addr  (rd_addr),
		.o_rd_data  (rd_data)
	);

	aud_player u_player (
		.i_clk_100k (i_clk_100k),
		.i_rst_n    (i_rst_n),
		.i_bclk     (i_bclk),
		.i_daclrck  (i_daclrck),
		.i_play_en  (play_en),
		.i_rd_data  (rd_data),
		.i_volume   (i_volume),
		.o_fetch    (fetch),
		.o_dacdat   (o_dacdat)
	);

endmodule

/* src/aud_ctrl.sv */
`timescale 1ns/1ps

module aud_ctrl #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                 i_clk_100k,
	input  logic                 i_rst_n,
	input  logic                 i_key_stop,
	input  logic                 i_key_play,
	input  logic                 i_key_rec,
	input  aud_pkg::sample_t     i_sample,
	input  logic                 i_sample_stb,
	input  logic                 i_fetch,
	output aud_pkg::mem_wr_t     o_wr,
	output aud_pkg::addr_t       o_rd_addr,
	output logic                 o_play_en,
	output aud_pkg::addr_t       o_rec_count,
	output aud_pkg::ctrl_state_t o_state
);
	import aud_pkg::*;

	// last address a recording may write
	localparam addr_t LAST_ADDR = addr_t'(MEM_DEPTH - 1);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	addr_t       rec_cnt_q;
	addr_t       play_cnt_q;
	logic        rec_acc;
	logic        rec_full;
	logic        play_adv;
	logic        play_done;
	logic        rec_clr;
	logic        play_clr;

	// strobes outside ST_REC are simply dropped
	assign rec_acc   = i_sample_stb & (state_q == ST_REC);
	assign rec_full  = rec_acc & (rec_cnt_q == LAST_ADDR);
	assign play_adv  = i_fetch & (state_q == ST_PLAY);
	assign play_done = (play_cnt_q == rec_cnt_q);

	assign rec_clr  = (state_q == ST_IDLE) & ~i_key_stop & i_key_rec;
	assign play_clr = (state_q == ST_IDLE) & ~i_key_stop & ~i_key_rec & i_key_play;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (i_key_stop) begin
					state_d = ST_IDLE;
				end else if (i_key_rec) begin
					state_d = ST_REC;
				end else if (i_key_play && rec_cnt_q != '0) begin
					state_d = ST_PLAY;
				end
			end
			ST_REC: begin
				if (i_key_stop || rec_full) begin
					state_d = ST_IDLE;
				end else if (i_key_rec) begin
					state_d = ST_REC_PAUSE;
				end
			end
			ST_REC_PAUSE: begin
				if (i_key_stop) begin
					state_d = ST_IDLE;
				end else if (i_key_rec) begin
					state_d = ST_REC;
				end
			end
			ST_PLAY: begin
				if (i_key_stop || play_done) begin
					state_d = ST_IDLE;
				end else if (i_key_play) begin
					state_d = ST_PLAY_PAUSE;
				end
			end
			ST_PLAY_PAUSE: begin
				if (i_key_stop) begin
					state_d = ST_IDLE;
				end else if (i_key_play) begin
					state_d = ST_PLAY;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// counters only move in the running states, so pause freezes them
	always_ff @(posedge i_clk_100k or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q    <= ST_IDLE;
			rec_cnt_q  <= '0;
			play_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			if (rec_clr) begin
				rec_cnt_q <= '0;
			end else if (rec_acc) begin
				rec_cnt_q <= rec_cnt_q + 1'b1;
			end
			if (play_clr) begin
				play_cnt_q <= '0;
			end else if (play_adv) begin
				play_cnt_q <= play_cnt_q + 1'b1;
			end
		end
	end

	assign o_wr.en     = rec_acc;
	assign o_wr.addr   = rec_cnt_q;
	assign o_wr.data   = i_sample;
	assign o_rd_addr   = play_cnt_q;
	assign o_play_en   = (state_q == ST_PLAY);
	assign o_rec_count = rec_cnt_q;
	assign o_state     = state_q;

endmodule

/* src/aud_player.sv */
`timescale 1ns/1ps

module aud_player (
	input  logic             i_clk_100k,
	input  logic             i_rst_n,
	input  logic             i_bclk,
	input  logic             i_daclrck,
	input  logic             i_play_en,
	input  aud_pkg::sample_t i_rd_data,
	input  aud_pkg::vol_t    i_volume,
	output logic             o_fetch,
	output logic             o_dacdat
);
	import aud_pkg::*;

	localparam int CNT_W = $clog2(SAMPLE_W + 1);

	logic             bclk_q;
	logic             lrck_q;
	logic             bclk_fall;
	logic             lrck_fall;
	logic             load_q;
	logic             shifting;
	logic [CNT_W-1:0] bits_left_q;
	vol_t             shamt;
	sample_t          scaled;
	sample_t          shift_q;

	assign bclk_fall = ~i_bclk & bclk_q;
	assign lrck_fall = ~i_daclrck & lrck_q;

	// volume as an arithmetic right shift
	assign shamt  = 3'd7 - i_volume;
	assign scaled = i_rd_data >>> shamt;

	assign shifting = (bits_left_q != '0);

	always_ff @(posedge i_clk_100k or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_q      <= 1'b0;
			lrck_q      <= 1'b0;
			o_fetch     <= 1'b0;
			load_q      <= 1'b0;
			bits_left_q <= '0;
			o_dacdat    <= 1'b0;
		end else begin
			bclk_q  <= i_bclk;
			lrck_q  <= i_daclrck;
			// one request per left frame while playing
			o_fetch <= lrck_fall & i_play_en;
			// a pause that lands on the fetch cycle drops the word
			load_q  <= o_fetch & i_play_en;
			if (load_q) begin
				bits_left_q <= CNT_W'(SAMPLE_W);
			end else if (bclk_fall) begin
				if (shifting) begin
					o_dacdat    <= shift_q[SAMPLE_W-1];
					bits_left_q <= bits_left_q - 1'b1;
				end else begin
					// line idles low between words
					o_dacdat <= 1'b0;
				end
			end
		end
	end

	// word in flight always finishes, even after playback ends
	always_ff @(posedge i_clk_100k) begin
		if (load_q) begin
			shift_q <= scaled;
		end else if (bclk_fall && shifting) begin
			shift_q <= shift_q << 1;
		end
	end

endmodule

/* src/aud_sample_mem.sv */
`timescale 1ns/1ps

module aud_sample_mem #(
	parameter int MEM_DEPTH = 256
) (
	input  logic             i_clk_100k,
	input  aud_pkg::mem_wr_t i_wr,
	input  aud_pkg::addr_t   i_rd_addr,
	output aud_pkg::sample_t o_rd_data
);
	import aud_pkg::*;

	// index width, the upper address bits stay zero below full depth
	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	sample_t            mem [MEM_DEPTH];
	logic [IDX_W-1:0]   wr_idx;
	logic [IDX_W-1:0]   rd_idx;

	assign wr_idx = i_wr.addr[IDX_W-1:0];
	assign rd_idx = i_rd_addr[IDX_W-1:0];

	// write port
	always_ff @(posedge i_clk_100k) begin
		if (i_wr.en) begin
			mem[wr_idx] <= i_wr.data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge i_clk_100k) begin
		o_rd_data <= mem[rd_idx];
	end

endmodule

/* src/aud_recorder.sv */
`timescale 1ns/1ps

module aud_recorder (
	input  logic             i_clk_100k,
	input  logic             i_rst_n,
	input  logic             i_bclk,
	input  logic             i_adclrck,
	input  logic             i_adcdat,
	output aud_pkg::sample_t o_sample,
	output logic             o_sample_stb
);
	import aud_pkg::*;

	localparam int CNT_W = $clog2(SAMPLE_W);

	logic             bclk_q;
	logic             lrck_q;
	logic             bclk_rise;
	logic             lrck_fall;
	logic             active_q;
	logic             shift_en;
	logic [CNT_W-1:0] bit_cnt_q;
	sample_t          shift_q;

	// edges of the codec clocks, seen one system cycle late
	assign bclk_rise = i_bclk & ~bclk_q;
	assign lrck_fall = ~i_adclrck & lrck_q;

	// left word only, the right half of the frame is ignored
	assign shift_en = active_q & bclk_rise & ~lrck_fall;

	always_ff @(posedge i_clk_100k or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_q       <= 1'b0;
			lrck_q       <= 1'b0;
			active_q     <= 1'b0;
			bit_cnt_q    <= '0;
			o_sample_stb <= 1'b0;
		end else begin
			bclk_q       <= i_bclk;
			lrck_q       <= i_adclrck;
			o_sample_stb <= 1'b0;
			if (lrck_fall) begin
				// new left word starts
				active_q  <= 1'b1;
				bit_cnt_q <= '0;
			end else if (shift_en) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (bit_cnt_q == CNT_W'(SAMPLE_W - 1)) begin
					// last bit in, word is complete
					active_q     <= 1'b0;
					o_sample_stb <= 1'b1;
				end
			end
		end
	end

	// msb arrives first
	always_ff @(posedge i_clk_100k) begin
		if (shift_en) begin
			shift_q <= {shift_q[SAMPLE_W-2:0], i_adcdat};
		end
	end

	// word stays put until the next left frame begins shifting
	assign o_sample = shift_q;

endmodule

/* src/aud_pkg.sv */
package aud_pkg;

	// serial word length on both the ADC and the DAC side
	localparam int SAMPLE_W = 16;

	// one signed audio sample
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// sample memory address of up to 64k entries
	typedef logic [15:0] addr_t;

	// volume level
	// 7 passes the sample through and each step down halves it once more
	typedef logic [2:0] vol_t;

	// one write into the sample memory
	typedef struct packed {
		logic    en;
		addr_t   addr;
		sample_t data;
	} mem_wr_t;

	// controller states
	// code 0 is left unused
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd1,
		ST_REC        = 3'd2,
		ST_REC_PAUSE  = 3'd3,
		ST_PLAY       = 3'd4,
		ST_PLAY_PAUSE = 3'd5
	} ctrl_state_t;

endpackage
